//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cpu_core
RTL_TOP   ?= cpu_core
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- cpu_core.sv
`timescale 1ns/1ps

module cpu_core
    import cpu_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    output logic  bus_cyc,
    output logic  bus_write,
    output word_t bus_addr,
    output word_t bus_wdata,
    input  word_t bus_rdata,
    input  logic  bus_ack,
    output logic  halt,
    output logic  fault
);

    // decode fields
    ir_type_t   ir_type;
    logic [3:0] ir_op;
    reg_addr_t  ir_ra;
    reg_addr_t  ir_rb;
    reg_addr_t  ir_rc;
    logic       ir_size;
    word_t      sval;
    logic       branch_taken;

    // sequencer controls
    logic       ir_write;
    logic       a_write;
    logic       b_write;
    logic       reg_write;
    logic       read_addr1;
    logic       read_addr2;
    logic       addr_mar;
    alu_func_t  alu_func;
    alu2_sel_t  alu2_sel;
    reg_sel_t   reg_sel;
    pc_sel_t    pc_sel;
    mar_sel_t   mar_sel;
    mdr_sel_t   mdr_sel;
    ccr_sel_t   ccr_sel;

    // data path values
    word_t      a_value;
    word_t      b_value;
    word_t      alu_out;
    word_t      wb_value;
    ccr_t       ccr;

    cpu_decode i_cpu_decode (.*);

    cpu_sequencer i_cpu_sequencer (.*);

    cpu_execute i_cpu_execute (.*);

    cpu_result i_cpu_result (.*);

endmodule

//--- cpu_decode.sv
`timescale 1ns/1ps

module cpu_decode
    import cpu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       ir_write,
    input  logic       bus_ack,
    input  word_t      bus_rdata,
    input  ccr_t       ccr,
    output ir_type_t   ir_type,
    output logic [3:0] ir_op,
    output reg_addr_t  ir_ra,
    output reg_addr_t  ir_rb,
    output reg_addr_t  ir_rc,
    output logic       ir_size,
    output word_t      sval,
    output logic       branch_taken
);

    word_t ir;
    logic  ccr_ltu;
    logic  ccr_lt;
    logic  ccr_eq;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            ir <= '0;                       // decodes as nop
        end else if (ir_write && bus_ack) begin
            ir <= bus_rdata;
        end
    end

    assign ir_type = ir[TYPE_POS +: 4];
    assign ir_op   = ir[OP_POS +: 4];
    assign ir_ra   = ir[RA_POS +: 4];
    assign ir_rb   = ir[RB_POS +: 4];
    assign ir_rc   = ir[RC_POS +: 4];
    assign ir_size = ir[0];
    assign sval    = {{17{ir[15]}}, ir[15:1]};

    assign {ccr_ltu, ccr_lt, ccr_eq} = ccr;

    always_comb begin
        case (ir_op)
            4'h0: branch_taken = 1'b1;                  // bra
            4'h1: branch_taken = ccr_eq;                // beq
            4'h2: branch_taken = ~ccr_eq;               // bne
            4'h3: branch_taken = ~(ccr_ltu | ccr_eq);   // bgtu
            4'h4: branch_taken = ~(ccr_lt | ccr_eq);    // bgt
            4'h5: branch_taken = ~ccr_lt;               // bge
            4'h6: branch_taken = ccr_lt | ccr_eq;       // ble
            4'h7: branch_taken = ccr_lt;                // blt
            4'h8: branch_taken = ~ccr_ltu;              // bgeu
            4'h9: branch_taken = ccr_ltu;               // bltu
            4'ha: branch_taken = ccr_ltu | ccr_eq;      // bleu
            default: branch_taken = 1'b0;               // brn
        endcase
    end

endmodule

//--- cpu_execute.sv
`timescale 1ns/1ps

module cpu_execute
    import cpu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  reg_addr_t ir_ra,
    input  reg_addr_t ir_rb,
    input  reg_addr_t ir_rc,
    input  logic      read_addr1,
    input  logic      read_addr2,
    input  logic      a_write,
    input  logic      b_write,
    input  logic      reg_write,
    input  alu_func_t alu_func,
    input  alu2_sel_t alu2_sel,
    input  ccr_sel_t  ccr_sel,
    input  word_t     sval,
    input  word_t     wb_value,
    output word_t     a_value,
    output word_t     b_value,
    output word_t     alu_out,
    output ccr_t      ccr
);

    word_t     regs [NUM_REGS];
    reg_addr_t rd1_addr;
    reg_addr_t rd2_addr;
    word_t     op2;
    logic      ltu;
    logic      lt;
    logic      eq;

    assign rd1_addr = (read_addr1 == RD1_RA) ? ir_ra : ir_rb;
    assign rd2_addr = (read_addr2 == RD2_RB) ? ir_rb : ir_rc;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
            ccr <= '0;
        end else begin
            if (reg_write) begin
                regs[ir_ra] <= wb_value;
            end
            if (ccr_sel == CCR_ALU) begin
                ccr <= {ltu, lt, eq};
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_write) begin
            a_value <= regs[rd1_addr];
        end
        if (b_write) begin
            b_value <= regs[rd2_addr];
        end
    end

    always_comb begin
        case (alu2_sel)
            ALU_4:    op2 = WORD_BYTES;
            ALU_SVAL: op2 = sval;
            default:  op2 = b_value;
        endcase
    end

    always_comb begin
        case (alu_func)
            ALU_ADD: alu_out = a_value + op2;
            ALU_SUB: alu_out = a_value - op2;
            ALU_AND: alu_out = a_value & op2;
            ALU_OR:  alu_out = a_value | op2;
            ALU_XOR: alu_out = a_value ^ op2;
            ALU_SHL: alu_out = a_value << op2[4:0];
            ALU_SHR: alu_out = a_value >> op2[4:0];
            ALU_ASR: alu_out = word_t'($signed(a_value) >>> op2[4:0]);
            default: alu_out = a_value;
        endcase
    end

    // flags of A minus B
    assign ltu = (a_value < b_value);
    assign lt  = ($signed(a_value) < $signed(b_value));
    assign eq  = (a_value == b_value);

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [2:0]  ccr_t;         // ltu, lt, eq
    typedef logic [3:0]  ir_type_t;
    typedef logic [2:0]  alu_func_t;
    typedef logic [1:0]  alu2_sel_t;
    typedef logic [1:0]  reg_sel_t;
    typedef logic [1:0]  pc_sel_t;
    typedef logic [1:0]  mar_sel_t;
    typedef logic [1:0]  mdr_sel_t;
    typedef logic        ccr_sel_t;

    localparam word_t WORD_BYTES = 32'd4;
    localparam int    NUM_REGS   = 16;

    localparam int TYPE_POS = 28;
    localparam int OP_POS   = 24;
    localparam int RA_POS   = 20;
    localparam int RB_POS   = 16;
    localparam int RC_POS   = 12;

    localparam ir_type_t T_INH    = 4'h0;
    localparam ir_type_t T_CMP    = 4'h3;
    localparam ir_type_t T_MOV    = 4'h4;
    localparam ir_type_t T_ALU    = 4'h9;
    localparam ir_type_t T_LDI    = 4'ha;
    localparam ir_type_t T_LOAD   = 4'hb;
    localparam ir_type_t T_STORE  = 4'hc;
    localparam ir_type_t T_BRANCH = 4'hd;

    localparam logic [3:0] OP_NOP  = 4'h0;
    localparam logic [3:0] OP_HALT = 4'h4;

    localparam alu_func_t ALU_ADD = 3'd0;
    localparam alu_func_t ALU_SUB = 3'd1;
    localparam alu_func_t ALU_AND = 3'd2;
    localparam alu_func_t ALU_OR  = 3'd3;
    localparam alu_func_t ALU_XOR = 3'd4;
    localparam alu_func_t ALU_SHL = 3'd5;
    localparam alu_func_t ALU_SHR = 3'd6;
    localparam alu_func_t ALU_ASR = 3'd7;

    localparam alu2_sel_t ALU_B    = 2'd0;
    localparam alu2_sel_t ALU_4    = 2'd1;
    localparam alu2_sel_t ALU_SVAL = 2'd2;

    localparam reg_sel_t REG_ALU = 2'd0;
    localparam reg_sel_t REG_B   = 2'd1;
    localparam reg_sel_t REG_MDR = 2'd2;

    localparam pc_sel_t PC_PC   = 2'd0;
    localparam pc_sel_t PC_NEXT = 2'd1;
    localparam pc_sel_t PC_REL  = 2'd2;

    localparam mar_sel_t MAR_MAR = 2'd0;
    localparam mar_sel_t MAR_ALU = 2'd1;

    localparam mdr_sel_t MDR_MDR = 2'd0;
    localparam mdr_sel_t MDR_BUS = 2'd1;
    localparam mdr_sel_t MDR_ALU = 2'd2;
    localparam mdr_sel_t MDR_A   = 2'd3;

    localparam ccr_sel_t CCR_CCR = 1'b0;
    localparam ccr_sel_t CCR_ALU = 1'b1;

    // register read port selects
    localparam logic RD1_RB = 1'b0;
    localparam logic RD1_RA = 1'b1;
    localparam logic RD2_RC = 1'b0;
    localparam logic RD2_RB = 1'b1;

    typedef enum logic [4:0] {
        S_FETCH,
        S_EVAL,
        S_ARG,
        S_CMP,
        S_CMP2,
        S_MOV,
        S_ALU,
        S_ALU2,
        S_LOAD,
        S_LOAD_BUS,
        S_STORE,
        S_STORE2,
        S_STORE_BUS,
        S_WB,
        S_HALT,
        S_FAULT
    } state_t;

endpackage

//--- cpu_result.sv
`timescale 1ns/1ps

module cpu_result
    import cpu_pkg::*;
(
    input  logic     clk_i,
    input  logic     rst_i,
    input  pc_sel_t  pc_sel,
    input  mar_sel_t mar_sel,
    input  mdr_sel_t mdr_sel,
    input  reg_sel_t reg_sel,
    input  logic     addr_mar,
    input  word_t    sval,
    input  word_t    alu_out,
    input  word_t    a_value,
    input  word_t    b_value,
    input  word_t    bus_rdata,
    input  logic     bus_ack,
    output word_t    bus_addr,
    output word_t    bus_wdata,
    output word_t    wb_value
);

    word_t pc;
    word_t mar;
    word_t mdr;

    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            pc <= '0;
        end else begin
            case (pc_sel)
                PC_NEXT: pc <= pc + WORD_BYTES;
                PC_REL:  pc <= pc + (sval << 2);    // offset counts words
                default: pc <= pc;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (mar_sel == MAR_ALU) begin
            mar <= alu_out;
        end
        case (mdr_sel)
            MDR_BUS: begin
                if (bus_ack) begin
                    mdr <= bus_rdata;
                end
            end
            MDR_ALU: mdr <= alu_out;
            MDR_A:   mdr <= a_value;
            default: mdr <= mdr;
        endcase
    end

    assign bus_addr  = addr_mar ? mar : pc;
    assign bus_wdata = mdr;

    always_comb begin
        case (reg_sel)
            REG_B:   wb_value = b_value;
            REG_MDR: wb_value = mdr;
            default: wb_value = alu_out;
        endcase
    end

endmodule

//--- cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer
    import cpu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  ir_type_t   ir_type,
    input  logic [3:0] ir_op,
    input  logic       ir_size,
    input  logic       branch_taken,
    input  logic       bus_ack,
    output logic       ir_write,
    output logic       a_write,
    output logic       b_write,
    output logic       reg_write,
    output logic       read_addr1,
    output logic       read_addr2,
    output alu_func_t  alu_func,
    output alu2_sel_t  alu2_sel,
    output reg_sel_t   reg_sel,
    output pc_sel_t    pc_sel,
    output mar_sel_t   mar_sel,
    output mdr_sel_t   mdr_sel,
    output ccr_sel_t   ccr_sel,
    output logic       addr_mar,
    output logic       bus_cyc,
    output logic       bus_write,
    output logic       halt,
    output logic       fault
);

    state_t state;
    state_t state_next;
    logic   ack;

    assign ack   = bus_cyc & bus_ack;   // ack only counts inside a cycle
    assign halt  = (state == S_HALT) || (state == S_FAULT);
    assign fault = (state == S_FAULT);

    // bus strobes registered from the next state so they stay steady for the transfer
    always_ff @(posedge clk_i or posedge rst_i) begin
        if (rst_i) begin
            state     <= S_FETCH;
            bus_cyc   <= 1'b0;
            bus_write <= 1'b0;
        end else begin
            state     <= state_next;
            bus_cyc   <= (state_next == S_FETCH) || (state_next == S_ARG) ||
                         (state_next == S_LOAD_BUS) || (state_next == S_STORE_BUS);
            bus_write <= (state_next == S_STORE_BUS);
        end
    end

    always_comb begin
        state_next = state;
        ir_write   = 1'b0;
        a_write    = 1'b0;
        b_write    = 1'b0;
        reg_write  = 1'b0;
        read_addr1 = RD1_RB;
        read_addr2 = RD2_RC;
        alu_func   = ALU_ADD;
        alu2_sel   = ALU_B;
        reg_sel    = REG_ALU;
        pc_sel     = PC_PC;
        mar_sel    = MAR_MAR;
        mdr_sel    = MDR_MDR;
        ccr_sel    = CCR_CCR;
        addr_mar   = 1'b0;

        case (state)
            S_FETCH: begin
                ir_write = bus_cyc;
                if (ack) begin
                    pc_sel     = PC_NEXT;
                    state_next = S_EVAL;
                end
            end
            S_EVAL: begin
                if (ir_size) begin
                    state_next = (ir_type == T_LDI) ? S_ARG : S_FAULT;
                end else begin
                    case (ir_type)
                        T_INH: begin
                            if (ir_op == OP_NOP) begin
                                state_next = S_FETCH;
                            end else if (ir_op == OP_HALT) begin
                                state_next = S_HALT;
                            end else begin
                                state_next = S_FAULT;
                            end
                        end
                        T_CMP: state_next = S_CMP;
                        T_MOV: begin
                            read_addr2 = RD2_RB;
                            b_write    = 1'b1;      // B <= rB
                            state_next = S_MOV;
                        end
                        T_ALU: state_next = S_ALU;
                        T_LOAD: begin
                            a_write    = 1'b1;      // A <= rB
                            state_next = S_LOAD;
                        end
                        T_STORE: begin
                            a_write    = 1'b1;      // A <= rB
                            state_next = S_STORE;
                        end
                        T_BRANCH: begin
                            if (branch_taken) begin
                                pc_sel = PC_REL;
                            end
                            state_next = S_FETCH;
                        end
                        default: state_next = S_FAULT;  // ldi without argument too
                    endcase
                end
            end
            S_ARG: begin
                mdr_sel = MDR_BUS;
                if (ack) begin
                    pc_sel     = PC_NEXT;
                    state_next = S_WB;
                end
            end
            S_CMP: begin
                read_addr1 = RD1_RA;
                read_addr2 = RD2_RB;
                a_write    = 1'b1;
                b_write    = 1'b1;
                state_next = S_CMP2;
            end
            S_CMP2: begin
                ccr_sel    = CCR_ALU;
                state_next = S_FETCH;
            end
            S_MOV: begin
                reg_sel    = REG_B;
                reg_write  = 1'b1;
                state_next = S_FETCH;
            end
            S_ALU: begin
                a_write    = 1'b1;          // A <= rB
                b_write    = 1'b1;          // B <= rC
                state_next = S_ALU2;
            end
            S_ALU2: begin
                alu_func   = ir_op[2:0];
                alu2_sel   = ir_op[3] ? ALU_SVAL : ALU_B;
                mdr_sel    = MDR_ALU;
                state_next = S_WB;
            end
            S_WB: begin
                reg_sel    = REG_MDR;       // rA <= MDR
                reg_write  = 1'b1;
                state_next = S_FETCH;
            end
            S_LOAD: begin
                alu2_sel   = ALU_SVAL;
                mar_sel    = MAR_ALU;
                state_next = S_LOAD_BUS;
            end
            S_LOAD_BUS: begin
                addr_mar = 1'b1;
                mdr_sel  = MDR_BUS;
                if (ack) begin
                    state_next = S_WB;
                end
            end
            S_STORE: begin
                alu2_sel   = ALU_SVAL;
                mar_sel    = MAR_ALU;
                read_addr1 = RD1_RA;
                a_write    = 1'b1;          // A <= rA once MAR has the address
                state_next = S_STORE2;
            end
            S_STORE2: begin
                mdr_sel    = MDR_A;
                state_next = S_STORE_BUS;
            end
            S_STORE_BUS: begin
                addr_mar = 1'b1;
                if (ack) begin
                    state_next = S_FETCH;
                end
            end
            default: state_next = state;    // halt and fault hold
        endcase
    end

endmodule

//--- tb_cpu_core.sv
`timescale 1ns/1ps

module tb_cpu_core
    import cpu_pkg::*;
;

    localparam int MEM_WORDS  = 256;
    localparam int MAX_EXPECT = 64;
    localparam int CLK_HALF   = 20;

    logic  clk_i;
    logic  rst_i;
    logic  bus_cyc;
    logic  bus_write;
    word_t bus_addr;
    word_t bus_wdata;
    word_t bus_rdata;
    logic  bus_ack;
    logic  halt;
    logic  fault;

    word_t       mem [MEM_WORDS];
    word_t       exp_addr [MAX_EXPECT];
    word_t       exp_data [MAX_EXPECT];
    int          exp_count;
    int          store_count;
    int          prog_words;
    logic        exp_fault;
    logic [15:0] lfsr;

    // request seen by the memory model
    logic        pending;
    int          wait_cnt;
    word_t       req_addr;
    logic        req_write;
    word_t       req_wdata;

    cpu_core i_cpu_core (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_HALF) clk_i = ~clk_i;
    end

    task automatic stop_run();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, name, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, name, actual, expected);
            stop_run();
        end
    endtask

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    // two lfsr bits give 0 to 3 wait cycles
    task automatic draw_wait(output int cycles);
        cycles = 0;
        for (int i = 0; i < 2; i++) begin
            cycles = cycles * 2 + int'(lfsr[0]);
            lfsr   = lfsr_next(lfsr);
        end
    endtask

    task automatic fill_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'hf000_0000 | word_t'(i * 4);    // illegal type if executed
        end
    endtask

    task automatic check_request();
        check_flag("bus_cyc", bus_cyc, 1'b1);
        check_word("bus_addr", bus_addr, req_addr);
        check_flag("bus_write", bus_write, req_write);
        if (req_write) begin
            check_word("bus_wdata", bus_wdata, req_wdata);
        end
    endtask

    task automatic complete_transfer();
        int idx;
        if (req_addr[1:0] != 2'b00 || req_addr >= MEM_WORDS * 4) begin
            report_error($sformatf("bus address %h lies outside the memory", req_addr));
        end else begin
            idx = int'(req_addr >> 2);
            bus_ack   <= 1'b1;
            bus_rdata <= mem[idx];
            if (req_write) begin
                if (store_count >= exp_count) begin
                    report_error($sformatf("extra store of %h to %h", req_wdata, req_addr));
                end else begin
                    check_word("store address", req_addr, exp_addr[store_count]);
                    check_word("store data", req_wdata, exp_data[store_count]);
                    mem[idx] = req_wdata;       // later loads see it
                    store_count++;
                end
            end
        end
    endtask

    // memory model acks each request after a random wait
    always @(posedge clk_i) begin
        if (rst_i) begin
            bus_ack <= 1'b0;
            pending = 1'b0;
        end else if (bus_ack) begin
            check_request();                    // still held on the ack edge
            bus_ack <= 1'b0;
            pending = 1'b0;
        end else if (bus_cyc || pending) begin
            if (pending) begin
                check_request();
            end else begin
                pending   = 1'b1;
                req_addr  = bus_addr;
                req_write = bus_write;
                req_wdata = bus_wdata;
                draw_wait(wait_cnt);
            end
            if (wait_cnt == 0) begin
                complete_transfer();
            end else begin
                wait_cnt--;
            end
        end
    end

    // reads lines up to the next end line and leaves found low at end of file
    task automatic load_section(input int fd, output logic found);
        string      line;
        logic [7:0] tag;
        word_t      addr;
        word_t      data;
        int         n;
        found      = 1'b0;
        exp_count  = 0;
        prog_words = 0;
        fill_memory();
        while (!found && !$feof(fd)) begin
            n   = $fgets(line, fd);
            tag = 8'h00;
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h", tag, addr, data);
            end
            case (tag)
                "p": begin
                    mem[addr[9:2]] = data;
                    prog_words++;
                end
                "e": begin
                    exp_addr[exp_count] = addr;
                    exp_data[exp_count] = data;
                    exp_count++;
                end
                "x": begin
                    exp_fault = addr[0];
                    found     = 1'b1;
                end
                default: ;                      // blank or comment
            endcase
        end
    endtask

    task automatic run_section(input int section);
        int cycles;
        int limit;
        limit       = prog_words * 12 * 4 + 50;
        store_count = 0;
        repeat (2) @(posedge clk_i);
        rst_i <= 1'b0;
        cycles = 0;
        while (halt !== 1'b1 && cycles < limit) begin
            @(negedge clk_i);
            cycles++;
        end
        if (halt !== 1'b1) begin
            report_error($sformatf("section %0d did not halt within %0d cycles",
                                   section, limit));
        end else if (store_count != exp_count) begin
            report_error($sformatf("section %0d halted after %0d of %0d stores",
                                   section, store_count, exp_count));
        end else begin
            check_flag("fault", fault, exp_fault);
            repeat (4) begin
                @(negedge clk_i);
                check_flag("bus_cyc", bus_cyc, 1'b0);
                check_flag("halt", halt, 1'b1);
            end
            $display("section %0d halted after %0d cycles, %0d stores",
                     section, cycles, store_count);
        end
    endtask

    initial begin
        int   fd;
        int   section;
        logic found;
        rst_i       = 1'b1;
        bus_ack     = 1'b0;
        bus_rdata   = '0;
        lfsr        = 16'd3046;
        pending     = 1'b0;
        wait_cnt    = 0;
        store_count = 0;
        exp_count   = 0;
        section     = 0;
        fd = $fopen("tb_input.txt", "r");
        if (fd == 0) begin
            report_error("cannot open tb_input.txt");
        end else begin
            load_section(fd, found);
            while (found) begin
                section++;
                run_section(section);
                @(posedge clk_i);
                rst_i <= 1'b1;                  // next section starts from reset
                load_section(fd, found);
            end
            $fclose(fd);
            if (section == 0) begin
                report_error("tb_input.txt holds no complete program section");
            end else begin
                $display("RESULT: PASS");
                $finish;
            end
        end
    end

endmodule

//--- tb_input.txt
# p <addr> <word>: program word, e <addr> <data>: expected store in program order
# x <f>: end of section, f = 1 when the run must stop with halt and fault
p 00000000 a0100001
p 00000004 800000f0
p 00000008 a0200001
p 0000000c 00000024
p 00000010 90312000
p 00000014 c0300400
p 00000018 99410020
p 0000001c c0400408
p 00000020 92512000
p 00000024 c0500410
p 00000028 9b611e0a
p 0000002c c0600418
p 00000030 94712000
p 00000034 c0700420
p 00000038 9d810008
p 0000003c c0800428
p 00000040 96912000
p 00000044 c0900430
p 00000048 9fa10008
p 0000004c c0a00438
p 00000050 40b20000
p 00000054 c06b03f8
p 00000058 b0cb03f8
p 0000005c c0c00448
p 00000060 c0b00450
p 00000064 30120000
p 00000068 d1000002
p 0000006c c0200458
p 00000070 d7000002
p 00000074 c0200500
p 00000078 d3000002
p 0000007c c0200500
p 00000080 d9000002
p 00000084 c0100460
p 00000088 30220000
p 0000008c d2000002
p 00000090 c0300468
p 00000094 da000002
p 00000098 c0200500
p 0000009c 30210000
p 000000a0 d5000002
p 000000a4 c0200500
p 000000a8 d8000002
p 000000ac c0400470
p 000000b0 04000000
e 00000200 80000114
e 00000204 800000e0
e 00000208 00000020
e 0000020c 80000ff5
e 00000210 800000d4
e 00000214 00000f00
e 00000218 0800000f
e 0000021c f800000f
e 00000220 80000ff5
e 00000224 80000ff5
e 00000228 00000024
e 0000022c 00000024
e 00000230 800000f0
e 00000234 80000114
e 00000238 800000e0
x 0
# second section ends on an illegal type
p 00000000 a0100001
p 00000004 0badc0de
p 00000008 c0100200
p 0000000c 10000000
p 00000010 04000000
e 00000100 0badc0de
x 1

//--- verilog.f
cpu_pkg.sv
cpu_decode.sv
cpu_sequencer.sv
cpu_execute.sv
cpu_result.sv
cpu_core.sv
tb_cpu_core.sv
